//--- rtl/router_params.svh
// Router parameters: port count, flit and destination widths, buffering and endpoints
`ifndef ROUTER_PARAMS_SVH
`define ROUTER_PARAMS_SVH

// Inputs and outputs of the router
`define ROUTER_NUM_PORTS 5

// Payload bits carried by one flit
`define ROUTER_FLIT_WIDTH 32

// Destination field width
`define ROUTER_DEST_WIDTH 3

// Entries in the routing table
`define ROUTER_NUM_ENDPOINTS 5

// Flits per input buffer, also the starting credit of each link
`define ROUTER_BUFFER_DEPTH 2

`endif

//--- rtl/router_pkg.sv
// Router types shared by the input units, allocator and output units
`include "router_params.svh"

package router_pkg;

    // Flit payload
    typedef logic [`ROUTER_FLIT_WIDTH-1:0] flit_t;

    // Destination endpoint carried by a head flit
    typedef logic [`ROUTER_DEST_WIDTH-1:0] dest_t;

    // Binary output port number
    typedef logic [$clog2(`ROUTER_NUM_PORTS)-1:0] port_sel_t;

    // One bit per port, bit i is input i
    typedef logic [`ROUTER_NUM_PORTS-1:0] port_mask_t;

    // Credit or occupancy count, 0 up to the buffer depth
    typedef logic [$clog2(`ROUTER_BUFFER_DEPTH+1)-1:0] credit_t;

endpackage

//--- rtl/flit_if.sv
// Flit link from one input unit to the switch allocator and the crossbar
interface flit_if;

    // Head of the input buffer
    logic                  valid;
    router_pkg::flit_t     flit;
    router_pkg::dest_t     dest;
    logic                  is_tail;

    // Output port looked up for the packet at the head
    router_pkg::port_sel_t route;

    // Head flit leaves the buffer at the end of this cycle
    logic                  advance;

    modport unit (
        output valid,
        output flit,
        output dest,
        output is_tail,
        output route,
        input  advance
    );

    modport sw (
        input  valid,
        input  flit,
        input  dest,
        input  is_tail,
        input  route,
        output advance
    );

endinterface

//--- rtl/input_unit.sv
// Input unit: buffers incoming flits and presents the head flit with its route
`include "router_params.svh"

module input_unit (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  router_pkg::flit_t                                  data_in,
    input  router_pkg::dest_t                                  dest_in,
    input  logic                                               is_tail_in,
    input  logic                                               send_in,
    input  router_pkg::port_sel_t [0:`ROUTER_NUM_ENDPOINTS-1]  route_table,
    output logic                                               credit_out,
    flit_if.unit                                               link
);
    localparam int DEPTH = `ROUTER_BUFFER_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    // Flit FIFO, payload and tail bit side by side
    router_pkg::flit_t   flit_mem [DEPTH];
    logic                tail_mem [DEPTH];
    logic [PTR_W-1:0]    flit_wr_ptr;
    logic [PTR_W-1:0]    flit_rd_ptr;
    router_pkg::credit_t flit_count;

    // Destination FIFO, one entry per buffered packet
    router_pkg::dest_t   dest_mem [DEPTH];
    logic [PTR_W-1:0]    dest_wr_ptr;
    logic [PTR_W-1:0]    dest_rd_ptr;
    router_pkg::credit_t dest_count;

    // Packet state on the write and read sides
    logic receiving;
    logic transiting;

    logic pop;
    logic dest_push;
    logic dest_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // A head flit is only shown once its destination is buffered
    assign link.valid   = (flit_count != '0) & (transiting | (dest_count != '0));
    assign link.flit    = flit_mem[flit_rd_ptr];
    assign link.is_tail = tail_mem[flit_rd_ptr];
    assign link.dest    = dest_mem[dest_rd_ptr];
    assign link.route   = route_table[dest_mem[dest_rd_ptr]];

    assign pop        = link.valid & link.advance;
    assign credit_out = pop;

    // Destination enters with the head and leaves with the tail
    assign dest_push = send_in & ~receiving;
    assign dest_pop  = pop & tail_mem[flit_rd_ptr];

    always_ff @(posedge clk) begin
        if (send_in) begin
            flit_mem[flit_wr_ptr] <= data_in;
            tail_mem[flit_wr_ptr] <= is_tail_in;
        end
        if (dest_push) begin
            dest_mem[dest_wr_ptr] <= dest_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flit_wr_ptr <= '0;
            flit_rd_ptr <= '0;
            flit_count  <= '0;
            dest_wr_ptr <= '0;
            dest_rd_ptr <= '0;
            dest_count  <= '0;
            receiving   <= 1'b0;
            transiting  <= 1'b0;
        end else begin
            if (send_in) begin
                flit_wr_ptr <= next_ptr(flit_wr_ptr);
                receiving   <= ~is_tail_in;
            end
            if (pop) begin
                flit_rd_ptr <= next_ptr(flit_rd_ptr);
                transiting  <= ~link.is_tail;
            end
            if (dest_push) begin
                dest_wr_ptr <= next_ptr(dest_wr_ptr);
            end
            if (dest_pop) begin
                dest_rd_ptr <= next_ptr(dest_rd_ptr);
            end
            flit_count <= flit_count + router_pkg::credit_t'(send_in)
                          - router_pkg::credit_t'(pop);
            dest_count <= dest_count + router_pkg::credit_t'(dest_push)
                          - router_pkg::credit_t'(dest_pop);
        end
    end

    // Upstream credit accounting keeps writes away from a full buffer
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        send_in |-> flit_count != router_pkg::credit_t'(DEPTH))
        else $error("input_unit: flit written into a full buffer");

endmodule

//--- rtl/switch_allocator.sv
// Switch allocator: one matrix arbiter per output, grant held for a whole packet
`include "router_params.svh"

module switch_allocator (
    input  logic                                           clk,
    input  logic                                           rst_n,
    flit_if.sw                                             heads [`ROUTER_NUM_PORTS],
    output router_pkg::port_mask_t [0:`ROUTER_NUM_PORTS-1] grant
);
    localparam int N = `ROUTER_NUM_PORTS;

    logic [N-1:0]          head_valid;
    logic [N-1:0]          head_tail;
    logic [N-1:0]          head_advance;
    router_pkg::port_sel_t head_route [N];

    for (genvar i = 0; i < N; i++) begin : g_heads
        assign head_valid[i]   = heads[i].valid;
        assign head_tail[i]    = heads[i].is_tail;
        assign head_advance[i] = heads[i].advance;
        assign head_route[i]   = heads[i].route;
    end

    for (genvar o = 0; o < N; o++) begin : g_outputs
        router_pkg::port_mask_t request;
        router_pkg::port_mask_t blocked;
        router_pkg::port_mask_t arb_grant;
        // Input that owns this output until its tail is sent
        router_pkg::port_mask_t held;
        // beats[i][j] set means input i wins over input j
        logic [N-1:0]           beats [N];
        logic                   sent;
        logic                   sent_tail;

        always_comb begin
            for (int i = 0; i < N; i++) begin
                request[i] = head_valid[i] & (head_route[i] == router_pkg::port_sel_t'(o));
            end
        end

        always_comb begin
            for (int i = 0; i < N; i++) begin
                blocked[i] = 1'b0;
                for (int j = 0; j < N; j++) begin
                    blocked[i] = blocked[i] | (request[j] & beats[j][i]);
                end
            end
        end

        assign arb_grant = request & ~blocked;
        assign grant[o]  = (held != '0) ? (held & request) : arb_grant;

        assign sent      = |(grant[o] & head_advance);
        assign sent_tail = |(grant[o] & head_advance & head_tail);

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                held <= '0;
                // Lower index starts with the higher priority
                for (int i = 0; i < N; i++) begin
                    for (int j = 0; j < N; j++) begin
                        beats[i][j] <= (i < j);
                    end
                end
            end else begin
                if (sent_tail) begin
                    held <= '0;
                end else if (sent) begin
                    held <= grant[o];
                end
                // The input that just sent drops below all others
                if (sent) begin
                    for (int i = 0; i < N; i++) begin
                        for (int j = 0; j < N; j++) begin
                            if (i != j) begin
                                beats[i][j] <= (beats[i][j] & ~grant[o][i]) | grant[o][j];
                            end
                        end
                    end
                end
            end
        end

        a_grant_valid: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(grant[o]) && ((grant[o] & ~request) == '0))
            else $error("switch_allocator: bad grant on output %0d", o);
    end

endmodule

//--- rtl/output_unit.sv
// Output unit: crossbar mux for one output, downstream credit counter and send
`include "router_params.svh"

module output_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    flit_if.sw                     heads [`ROUTER_NUM_PORTS],
    input  router_pkg::port_mask_t grant,
    input  logic                   credit_in,
    output router_pkg::flit_t      data_out,
    output router_pkg::dest_t      dest_out,
    output logic                   is_tail_out,
    output logic                   send
);
    localparam int N     = `ROUTER_NUM_PORTS;
    localparam int DEPTH = `ROUTER_BUFFER_DEPTH;

    router_pkg::flit_t   head_flit [N];
    router_pkg::dest_t   head_dest [N];
    logic [N-1:0]        head_valid;
    logic [N-1:0]        head_tail;
    logic                sel_valid;
    // Free slots in the downstream buffer
    router_pkg::credit_t credits;

    for (genvar i = 0; i < N; i++) begin : g_heads
        assign head_flit[i]  = heads[i].flit;
        assign head_dest[i]  = heads[i].dest;
        assign head_valid[i] = heads[i].valid;
        assign head_tail[i]  = heads[i].is_tail;
    end

    // One-hot mux, at most one grant bit is set
    always_comb begin
        data_out    = '0;
        dest_out    = '0;
        is_tail_out = 1'b0;
        sel_valid   = 1'b0;
        for (int i = 0; i < N; i++) begin
            if (grant[i]) begin
                data_out    = data_out | head_flit[i];
                dest_out    = dest_out | head_dest[i];
                is_tail_out = is_tail_out | head_tail[i];
                sel_valid   = sel_valid | head_valid[i];
            end
        end
    end

    assign send = sel_valid & (credits != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits <= router_pkg::credit_t'(DEPTH);
        end else begin
            credits <= credits + router_pkg::credit_t'(credit_in)
                       - router_pkg::credit_t'(send);
        end
    end

    // Downstream never returns more credits than its buffer holds
    a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= router_pkg::credit_t'(DEPTH))
        else $error("output_unit: credit count above buffer depth");

endmodule

//--- rtl/router.sv
// Five-port wormhole router with credit flow control on every link
`include "router_params.svh"

module router (
    input  logic                                               clk,
    input  logic                                               rst_n,

    input  router_pkg::flit_t     [0:`ROUTER_NUM_PORTS-1]      data_in,
    input  router_pkg::dest_t     [0:`ROUTER_NUM_PORTS-1]      dest_in,
    input  logic                  [0:`ROUTER_NUM_PORTS-1]      is_tail_in,
    input  logic                  [0:`ROUTER_NUM_PORTS-1]      send_in,
    output logic                  [0:`ROUTER_NUM_PORTS-1]      credit_out,

    output router_pkg::flit_t     [0:`ROUTER_NUM_PORTS-1]      data_out,
    output router_pkg::dest_t     [0:`ROUTER_NUM_PORTS-1]      dest_out,
    output logic                  [0:`ROUTER_NUM_PORTS-1]      is_tail_out,
    output logic                  [0:`ROUTER_NUM_PORTS-1]      send_out,
    input  logic                  [0:`ROUTER_NUM_PORTS-1]      credit_in,

    input  router_pkg::port_sel_t [0:`ROUTER_NUM_ENDPOINTS-1]  route_table
);
    localparam int N = `ROUTER_NUM_PORTS;

    flit_if links [N] ();

    // Grant per output, bit i selects input i
    router_pkg::port_mask_t [0:N-1] grant;

    for (genvar i = 0; i < N; i++) begin : g_inputs
        logic [N-1:0] sent_from;

        // Input i advances when whichever output granted it sends
        for (genvar o = 0; o < N; o++) begin : g_sends
            assign sent_from[o] = send_out[o] & grant[o][i];
        end
        assign links[i].advance = |sent_from;

        input_unit u_input (
            .clk         (clk),
            .rst_n       (rst_n),
            .data_in     (data_in[i]),
            .dest_in     (dest_in[i]),
            .is_tail_in  (is_tail_in[i]),
            .send_in     (send_in[i]),
            .route_table (route_table),
            .credit_out  (credit_out[i]),
            .link        (links[i])
        );
    end

    switch_allocator u_alloc (
        .clk   (clk),
        .rst_n (rst_n),
        .heads (links),
        .grant (grant)
    );

    for (genvar o = 0; o < N; o++) begin : g_outputs
        output_unit u_output (
            .clk         (clk),
            .rst_n       (rst_n),
            .heads       (links),
            .grant       (grant[o]),
            .credit_in   (credit_in[o]),
            .data_out    (data_out[o]),
            .dest_out    (dest_out[o]),
            .is_tail_out (is_tail_out[o]),
            .send        (send_out[o])
        );
    end

endmodule

//--- tb/router_tb.sv
// Router testbench: random packets with credit models, checked by concurrent assertions
`include "router_params.svh"

module router_tb;
    localparam int N        = `ROUTER_NUM_PORTS;
    localparam int DEPTH    = `ROUTER_BUFFER_DEPTH;
    localparam int MAXF     = 256;
    localparam int TIMEOUT  = 5000;
    localparam int ARB_OUT  = 2;
    localparam int ARB_DEST = 2;

    logic clk;
    logic rst_n;
    router_pkg::flit_t     [0:N-1]                     data_in;
    router_pkg::dest_t     [0:N-1]                     dest_in;
    logic                  [0:N-1]                     is_tail_in;
    logic                  [0:N-1]                     send_in;
    logic                  [0:N-1]                     credit_out;
    router_pkg::flit_t     [0:N-1]                     data_out;
    router_pkg::dest_t     [0:N-1]                     dest_out;
    logic                  [0:N-1]                     is_tail_out;
    logic                  [0:N-1]                     send_out;
    logic                  [0:N-1]                     credit_in;
    router_pkg::port_sel_t [0:`ROUTER_NUM_ENDPOINTS-1] route_table;

    // Flit log per input, indexed by enqueue order
    router_pkg::flit_t fl_data [N][MAXF];
    router_pkg::dest_t fl_dest [N][MAXF];
    logic              fl_tail [N][MAXF];
    int wr_idx [N];
    int tx_idx [N];
    int rx_idx [N];
    int up_credit [N];
    int owed [N];
    int open_src [N];
    int pkt_num [N];
    int arb_seq [3] = '{1, 3, 1};
    int arb_pos;
    int hold_out;
    int held_sent;
    int seed;
    logic idle_check;

    // Output values taken mid-cycle, applied to the scoreboard after the next edge
    logic              [0:N-1] snap_send;
    logic              [0:N-1] snap_tail;
    logic              [0:N-1] snap_credit;
    router_pkg::flit_t [0:N-1] snap_data;

    router DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_mismatch(string test, logic [63:0] expected, logic [63:0] actual);
        $display("ERR %s expected %h actual %h", test, expected, actual);
        $display("TESTS FAILED");
        $fatal(1, "check failed in %s", test);
    endtask

    // Packed view of one output flit: payload, destination, tail and output port
    function automatic logic [63:0] actual_out(router_pkg::flit_t d, router_pkg::dest_t t,
                                               logic tail, int o);
        return {25'd0, d, t, tail, 3'(o)};
    endfunction

    // Next flit owed by the source named in the payload
    function automatic logic [63:0] expected_out(router_pkg::flit_t d);
        int src;
        int k;
        src = int'(d[31:24]);
        if (src >= N || rx_idx[src] >= wr_idx[src]) begin
            return '1;
        end
        k = rx_idx[src];
        return {25'd0, fl_data[src][k], fl_dest[src][k], fl_tail[src][k],
                route_table[fl_dest[src][k]]};
    endfunction

    function automatic logic sends_from(logic [0:N-1] send, router_pkg::flit_t [0:N-1] d,
                                        int s);
        logic hit;
        hit = 1'b0;
        for (int o = 0; o < N; o++) begin
            if (send[o] && int'(d[o][31:24]) == s) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    for (genvar p = 0; p < N; p++) begin : g_checks
        a_route: assert property (@(posedge clk) disable iff (!rst_n)
            send_out[p] |-> actual_out(data_out[p], dest_out[p], is_tail_out[p], p)
                            == expected_out(data_out[p]))
            else report_mismatch("routing", expected_out($sampled(data_out[p])),
                actual_out($sampled(data_out[p]), $sampled(dest_out[p]),
                           $sampled(is_tail_out[p]), p));

        a_wormhole: assert property (@(posedge clk) disable iff (!rst_n)
            (send_out[p] && open_src[p] >= 0) |-> int'(data_out[p][31:24]) == open_src[p])
            else report_mismatch("wormhole", open_src[p], $sampled(data_out[p][31:24]));

        a_credit: assert property (@(posedge clk) disable iff (!rst_n)
            credit_out[p] == sends_from(send_out, data_out, p))
            else report_mismatch("credit return", sends_from($sampled(send_out),
                $sampled(data_out), p), $sampled(credit_out[p]));

        a_hold: assert property (@(posedge clk) disable iff (!rst_n)
            (hold_out == p && send_out[p]) |-> held_sent < DEPTH)
            else report_mismatch("back-pressure", DEPTH, held_sent + 1);
    end

    a_idle: assert property (@(posedge clk)
        idle_check |-> (send_out == '0 && credit_out == '0))
        else report_mismatch("reset", '0, {$sampled(send_out), $sampled(credit_out)});

    a_arb: assert property (@(posedge clk) disable iff (!rst_n)
        (send_out[ARB_OUT] && open_src[ARB_OUT] < 0 && arb_pos < 3)
        |-> int'(data_out[ARB_OUT][31:24]) == arb_seq[arb_pos])
        else report_mismatch("arbitration", arb_seq[arb_pos],
                             $sampled(data_out[ARB_OUT][31:24]));

    always @(negedge clk) begin
        snap_send   = send_out;
        snap_tail   = is_tail_out;
        snap_credit = credit_out;
        snap_data   = data_out;
    end

    // Scoreboard update, downstream credit model and upstream driver
    always @(posedge clk) begin
        int src;
        #1;
        for (int s = 0; s < N; s++) begin
            if (snap_credit[s] === 1'b1) begin
                up_credit[s]++;
            end
        end
        for (int o = 0; o < N; o++) begin
            if (snap_send[o] === 1'b1) begin
                src = int'(snap_data[o][31:24]);
                if (src < N) begin
                    rx_idx[src]++;
                end
                if (o == ARB_OUT && open_src[o] < 0) begin
                    arb_pos++;
                end
                if (o == hold_out) begin
                    held_sent++;
                end
                open_src[o] = snap_tail[o] ? -1 : src;
                owed[o]++;
            end
            credit_in[o] = (owed[o] > 0) && (o != hold_out) && (($random(seed) & 1) != 0);
            if (credit_in[o]) begin
                owed[o]--;
            end
        end
        for (int s = 0; s < N; s++) begin
            send_in[s] = 1'b0;
            if (tx_idx[s] < wr_idx[s] && up_credit[s] > 0) begin
                send_in[s]    = 1'b1;
                data_in[s]    = fl_data[s][tx_idx[s]];
                dest_in[s]    = fl_dest[s][tx_idx[s]];
                is_tail_in[s] = fl_tail[s][tx_idx[s]];
                tx_idx[s]++;
                up_credit[s]--;
            end
        end
    end

    // Payload holds source, packet number and flit index above a random byte
    task automatic add_packet(int s, int d, int len);
        for (int k = 0; k < len; k++) begin
            fl_data[s][wr_idx[s]] = {8'(s), 8'(pkt_num[s]), 8'(k), 8'($random(seed))};
            fl_dest[s][wr_idx[s]] = router_pkg::dest_t'(d);
            fl_tail[s][wr_idx[s]] = (k == len - 1);
            wr_idx[s]++;
        end
        pkt_num[s]++;
    endtask

    // Mode 0 waits for all inputs, mode 1 skips the held input, mode 2 counts held flits
    function automatic logic condition_met(int mode);
        if (mode == 2) begin
            return held_sent == DEPTH;
        end
        for (int s = 0; s < N; s++) begin
            if (!(mode == 1 && s == hold_out)) begin
                if (rx_idx[s] != wr_idx[s] || up_credit[s] != DEPTH || owed[s] != 0) begin
                    return 1'b0;
                end
            end
        end
        return 1'b1;
    endfunction

    task automatic wait_until(int mode, string what);
        int cycles;
        cycles = 0;
        while (!condition_met(mode)) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Timed out waiting for %s", what);
                $display("TESTS FAILED");
                $fatal(1, "timeout");
            end
        end
    endtask

    initial begin
        int src;
        int dst;
        seed       = 32'ha425_e094;
        rst_n      = 1'b0;
        data_in    = '0;
        dest_in    = '0;
        is_tail_in = '0;
        send_in    = '0;
        credit_in  = '0;
        idle_check = 1'b0;
        hold_out   = -1;
        held_sent  = 0;
        arb_pos    = 0;
        for (int s = 0; s < N; s++) begin
            wr_idx[s]    = 0;
            tx_idx[s]    = 0;
            rx_idx[s]    = 0;
            up_credit[s] = DEPTH;
            owed[s]      = 0;
            open_src[s]  = -1;
            pkt_num[s]   = 0;
        end
        for (int d = 0; d < `ROUTER_NUM_ENDPOINTS; d++) begin
            route_table[d] = router_pkg::port_sel_t'(N - 1 - d);
        end
        @(posedge clk);
        #1 idle_check = 1'b1;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (8) @(posedge clk);
        #1 idle_check = 1'b0;

        // Inputs 1 and 3 contend for one output, then input 1 returns
        @(negedge clk);
        add_packet(1, ARB_DEST, 2);
        add_packet(3, ARB_DEST, 2);
        add_packet(1, ARB_DEST, 2);
        wait_until(0, "arbitration traffic");

        for (int p = 0; p < 30; p++) begin
            src = $unsigned($random(seed)) % N;
            dst = $unsigned($random(seed)) % `ROUTER_NUM_ENDPOINTS;
            add_packet(src, dst, 1 + $unsigned($random(seed)) % 4);
        end
        wait_until(0, "random traffic");

        // Output 0 gets no credits back while outputs 3 and 1 keep moving
        hold_out = 0;
        add_packet(0, 4, 5);
        add_packet(2, 1, 3);
        add_packet(4, 3, 3);
        wait_until(2, "flits on the held output");
        wait_until(1, "traffic to the other outputs");
        hold_out = -1;
        wait_until(0, "traffic after credits resume");

        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- sim.f
+incdir+rtl
rtl/router_pkg.sv
rtl/flit_if.sv
rtl/input_unit.sv
rtl/switch_allocator.sv
rtl/output_unit.sv
rtl/router.sv
tb/router_tb.sv
